// ==== tests/ex_stimulus.txt ====
// funct special2 rs_val rt_val shamt exp_data exp_overflow exp_invalid (all hex)
// first word is the number of tests
2e
// add, sub, logic, set-less-than
20 0 7fffffff 00000001 00 00000000 1 0
20 0 fffffffe 00000003 00 00000001 0 0
21 0 7fffffff 00000001 00 80000000 0 0
22 0 80000000 00000001 00 00000000 1 0
23 0 00000000 00000001 00 ffffffff 0 0
24 0 f0f0f0f0 3c3c3c3c 00 30303030 0 0
25 0 12340000 00005678 00 12345678 0 0
26 0 ffff0000 0ff00ff0 00 f00f0ff0 0 0
27 0 0000ffff 00ff0000 00 ff000000 0 0
2a 0 80000000 7fffffff 00 00000001 0 0
2b 0 80000000 7fffffff 00 00000000 0 0
// shifts
00 0 00000000 00000001 1f 80000000 0 0
02 0 00000000 80000000 04 08000000 0 0
03 0 00000000 80000000 04 f8000000 0 0
04 0 00000024 0000000f 03 000000f0 0 0
06 0 00000008 f0000000 00 00f00000 0 0
07 0 0000001f 80000000 00 ffffffff 0 0
// leading count, invalid codes
20 1 00000000 00000000 00 00000020 0 0
21 1 ffffffff 00000000 00 00000020 0 0
20 1 00010000 00000000 00 0000000f 0 0
21 1 7fffffff 00000000 00 00000000 0 0
00 1 00000000 00000000 00 00000000 0 1
01 0 00000000 00000000 00 00000000 0 1
// hi/lo moves and multiplies
11 0 deadbeef 00000000 00 00000000 0 0
13 0 01234567 00000000 00 00000000 0 0
10 0 00000000 00000000 00 deadbeef 0 0
12 0 00000000 00000000 00 01234567 0 0
18 0 fffffffd fffffff9 00 00000000 0 0
10 0 00000000 00000000 00 00000000 0 0
12 0 00000000 00000000 00 00000015 0 0
19 0 ffffffff ffffffff 00 00000000 0 0
10 0 00000000 00000000 00 fffffffe 0 0
12 0 00000000 00000000 00 00000001 0 0
// burst behind multiplies
18 0 00010000 00010000 00 00000000 0 0
21 0 00000005 00000006 00 0000000b 0 0
26 0 aaaaaaaa 55555555 00 ffffffff 0 0
03 0 00000000 c0000000 01 e0000000 0 0
10 0 00000000 00000000 00 00000001 0 0
12 0 00000000 00000000 00 00000000 0 0
19 0 12345678 00000010 00 00000000 0 0
23 0 00000010 00000020 00 fffffff0 0 0
20 1 00000001 00000000 00 0000001f 0 0
12 0 00000000 00000000 00 23456780 0 0
10 0 00000000 00000000 00 00000001 0 0
2a 0 ffffffff 00000001 00 00000001 0 0
22 0 00000005 00000007 00 fffffffe 0 0

// ==== flist.f ====
+incdir+include
logic/ex_pkg.sv
logic/stage_if.sv
logic/op_decode.sv
logic/issue_queue.sv
logic/count_lead.sv
logic/mul_unit.sv
logic/exec_unit.sv
logic/ex_top.sv
tests/ex_checker.sv
tests/tb_ex_top.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_ex_top -f flist.f

out=$(./obj_dir/Vtb_ex_top)
echo "$out"

if echo "$out" | grep -q "^Testbench passed$"; then
	exit 0
else
	exit 1
fi

// ==== tests/tb_ex_top.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "ex_params.svh"

module tb_ex_top;

	localparam int MAX_TESTS = 64;
	localparam int COLS      = 8;

	logic                clk;
	logic                rst;
	logic                in_req;
	logic                in_ack;
	logic [5:0]          in_funct;
	logic                in_special2;
	logic [`EX_WORD-1:0] in_rs_val;
	logic [`EX_WORD-1:0] in_rt_val;
	logic [4:0]          in_shamt;
	logic                out_req;
	logic                out_ack;
	logic [`EX_WORD-1:0] out_data;
	logic                out_overflow;
	logic                out_invalid;

	// word 0 is the test count, then COLS words per test
	logic [31:0]         stim_mem [0:MAX_TESTS*COLS];
	logic [5:0]          t_funct [MAX_TESTS];
	logic                t_special2 [MAX_TESTS];
	logic [`EX_WORD-1:0] t_rs [MAX_TESTS];
	logic [`EX_WORD-1:0] t_rt [MAX_TESTS];
	logic [4:0]          t_shamt [MAX_TESTS];
	logic [`EX_WORD-1:0] exp_data [MAX_TESTS];
	logic                exp_ov [MAX_TESTS];
	logic                exp_inv [MAX_TESTS];
	int                  num_tests;
	bit                  loaded = 1'b0;
	logic [31:0]         src_lfsr;
	logic [31:0]         snk_lfsr;
	int                  n_pass;
	int                  n_fail;
	int                  n_done;

	ex_top dut (
		.clk,
		.rst,
		.in_req,
		.in_ack,
		.in_funct,
		.in_special2,
		.in_rs_val,
		.in_rt_val,
		.in_shamt,
		.out_req,
		.out_ack,
		.out_data,
		.out_overflow,
		.out_invalid
	);

	ex_checker chk (
		.clk,
		.rst,
		.out_req,
		.out_data,
		.out_overflow,
		.out_invalid,
		.n_pass,
		.n_fail,
		.n_done
	);

	always #4 clk = ~clk;

	// galois form, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic take_bits(inout logic [31:0] state, input int n, output int val);
		val = 0;
		for (int i = 0; i < n; i++)
		begin
			val   = (val << 1) | int'(state[0]);
			state = lfsr_step(state);
		end
	endtask

	task automatic load_stimulus();
		int base;
		$readmemh("tests/ex_stimulus.txt", stim_mem);
		num_tests = int'(stim_mem[0]);
		if (num_tests > MAX_TESTS)
		begin
			$display("stimulus file holds more tests than the testbench can store");
			num_tests = 0;
		end
		for (int t = 0; t < num_tests; t++)
		begin
			base          = 1 + t * COLS;
			t_funct[t]    = stim_mem[base][5:0];
			t_special2[t] = stim_mem[base+1][0];
			t_rs[t]       = stim_mem[base+2];
			t_rt[t]       = stim_mem[base+3];
			t_shamt[t]    = stim_mem[base+4][4:0];
			exp_data[t]   = stim_mem[base+5];
			exp_ov[t]     = stim_mem[base+6][0];
			exp_inv[t]    = stim_mem[base+7][0];
		end
	endtask

	// called at a falling edge, returns once the source side is idle again
	task automatic send_op(input int t);
		in_funct    = t_funct[t];
		in_special2 = t_special2[t];
		in_rs_val   = t_rs[t];
		in_rt_val   = t_rt[t];
		in_shamt    = t_shamt[t];
		in_req      = 1'b1;
		while (!in_ack)
			@(negedge clk);
		in_req = 1'b0;
		while (in_ack)
			@(negedge clk);
	endtask

	initial
	begin : main
		int gap;
		clk         = 1'b0;
		rst         = 1'b1;
		in_req      = 1'b0;
		in_funct    = '0;
		in_special2 = 1'b0;
		in_rs_val   = '0;
		in_rt_val   = '0;
		in_shamt    = '0;
		src_lfsr    = 32'h9f5d;
		load_stimulus();
		loaded = 1'b1;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		for (int t = 0; t < num_tests; t++)
		begin
			take_bits(src_lfsr, 2, gap);
			repeat (gap + 1) @(negedge clk);
			send_op(t);
		end
		while (n_done < num_tests)
			@(posedge clk);
		// room for a stray extra result
		repeat (10) @(posedge clk);
		$display("%0d of %0d tests passed, %0d failed", n_pass, num_tests, n_fail);
		if (n_fail == 0 && n_pass == num_tests && num_tests > 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	// result sink with long random delays to back up the queue
	initial
	begin : sink
		int gap;
		out_ack  = 1'b0;
		snk_lfsr = 32'h9f5d;
		forever
		begin
			@(negedge clk);
			if (out_req && !out_ack)
			begin
				take_bits(snk_lfsr, 2, gap);
				repeat (gap * 4) @(negedge clk);
				out_ack = 1'b1;
			end
			else if (!out_req && out_ack)
				out_ack = 1'b0;
		end
	end

	initial
	begin : watchdog
		wait (loaded);
		repeat ((num_tests + 1) * (`EX_MUL_CYCLES + 40)) @(posedge clk);
		$display("timeout: results stopped arriving");
		$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/ex_checker.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "ex_params.svh"

module ex_checker (
	input  logic                clk,
	input  logic                rst,
	input  logic                out_req,
	input  logic [`EX_WORD-1:0] out_data,
	input  logic                out_overflow,
	input  logic                out_invalid,
	output int                  n_pass,
	output int                  n_fail,
	output int                  n_done
);

	logic req_seen;

	// results come back in input order, so n_done indexes the expected arrays
	task automatic check_result();
		logic [`EX_WORD-1:0] want_data;
		logic                want_ov;
		logic                want_inv;
		if (n_done >= tb_ex_top.num_tests)
		begin
			$display("unexpected result at %0t after every test had its result", $time);
			n_fail = n_fail + 1;
		end
		else
		begin
			want_data = tb_ex_top.exp_data[n_done];
			want_ov   = tb_ex_top.exp_ov[n_done];
			want_inv  = tb_ex_top.exp_inv[n_done];
			if (out_data !== want_data)
			begin
				$display("error at %0t: test %0d data mismatch, got %h expected %h",
					$time, n_done + 1, out_data, want_data);
				n_fail = n_fail + 1;
			end
			else if (out_overflow !== want_ov || out_invalid !== want_inv)
			begin
				$display("error at %0t: test %0d flag mismatch, got ov %b inv %b expected %b %b",
					$time, n_done + 1, out_overflow, out_invalid, want_ov, want_inv);
				n_fail = n_fail + 1;
			end
			else
			begin
				$display("test %0d passed", n_done + 1);
				n_pass = n_pass + 1;
			end
		end
		n_done = n_done + 1;
	endtask

	always @(negedge clk)
	begin
		if (rst)
		begin
			req_seen = 1'b0;
			n_pass   = 0;
			n_fail   = 0;
			n_done   = 0;
		end
		else
		begin
			if (out_req && !req_seen)
				check_result();
			req_seen = out_req;
		end
	end

endmodule

`default_nettype wire

// ==== logic/ex_top.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "ex_params.svh"

module ex_top (
	input  logic                clk,
	input  logic                rst,
	input  logic                in_req,
	output logic                in_ack,
	input  logic [5:0]          in_funct,
	input  logic                in_special2,
	input  logic [`EX_WORD-1:0] in_rs_val,
	input  logic [`EX_WORD-1:0] in_rt_val,
	input  logic [4:0]          in_shamt,
	output logic                out_req,
	input  logic                out_ack,
	output logic [`EX_WORD-1:0] out_data,
	output logic                out_overflow,
	output logic                out_invalid
);

	stage_if dec_q ();
	stage_if q_ex ();

	op_decode u_decode (
		.clk,
		.rst,
		.in_req,
		.in_ack,
		.in_funct,
		.in_special2,
		.in_rs_val,
		.in_rt_val,
		.in_shamt,
		.q(dec_q.sender)
	);

	issue_queue u_queue (
		.clk,
		.rst,
		.up(dec_q.receiver),
		.down(q_ex.sender)
	);

	exec_unit u_exec (
		.clk,
		.rst,
		.q(q_ex.receiver),
		.out_req,
		.out_ack,
		.out_data,
		.out_overflow,
		.out_invalid
	);

endmodule

`default_nettype wire

// ==== logic/exec_unit.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "ex_params.svh"

module exec_unit (
	input  logic                clk,
	input  logic                rst,
	stage_if.receiver           q,
	output logic                out_req,
	input  logic                out_ack,
	output logic [`EX_WORD-1:0] out_data,
	output logic                out_overflow,
	output logic                out_invalid
);

	localparam int W = `EX_WORD;

	ex_pkg::exec_state_t state;
	ex_pkg::op_t         op_r;
	logic [W-1:0]        rs_r;
	logic [W-1:0]        rt_r;
	logic [4:0]          shamt_r;
	logic [W-1:0]        hi;
	logic [W-1:0]        lo;
	logic [W-1:0]        add_u;
	logic [W-1:0]        sub_u;
	logic [W-1:0]        alu_data;
	logic [W-1:0]        clz_cnt;
	logic [W-1:0]        clo_cnt;
	logic [2*W-1:0]      mul_product;
	logic                mul_busy;
	logic                accept;
	logic                is_mul;
	logic                signed_lt;
	logic                ov_add;
	logic                ov_sub;
	logic                overflow;

	assign accept = (state == ex_pkg::IDLE) && q.req && !q.ack;
	assign is_mul = (q.op == ex_pkg::OP_MULT) || (q.op == ex_pkg::OP_MULTU);

	// multiplier starts straight off the queue fields
	mul_unit mul (
		.clk,
		.rst,
		.start(accept && is_mul),
		.is_signed(q.op == ex_pkg::OP_MULT),
		.a(q.rs_val),
		.b(q.rt_val),
		.busy(mul_busy),
		.product(mul_product)
	);

	count_lead clz_count (.bit_val(1'b0), .val(rs_r), .count(clz_cnt));
	count_lead clo_count (.bit_val(1'b1), .val(rs_r), .count(clo_cnt));

	assign add_u     = rs_r + rt_r;
	assign sub_u     = rs_r - rt_r;
	assign signed_lt = (rs_r[W-1] != rt_r[W-1]) ? rs_r[W-1] : sub_u[W-1];
	assign ov_add    = (rs_r[W-1] == rt_r[W-1]) && (rs_r[W-1] ^ add_u[W-1]);
	assign ov_sub    = (rs_r[W-1] ^ rt_r[W-1]) && (rs_r[W-1] ^ sub_u[W-1]);
	assign overflow  = ((op_r == ex_pkg::OP_ADD) && ov_add) ||
		((op_r == ex_pkg::OP_SUB) && ov_sub);

	always_comb
	begin
		case (op_r)
			ex_pkg::OP_SLL:  alu_data = rt_r << shamt_r;
			ex_pkg::OP_SRL:  alu_data = rt_r >> shamt_r;
			ex_pkg::OP_SRA:  alu_data = $signed(rt_r) >>> shamt_r;
			ex_pkg::OP_SLLV: alu_data = rt_r << rs_r[4:0];
			ex_pkg::OP_SRLV: alu_data = rt_r >> rs_r[4:0];
			ex_pkg::OP_SRAV: alu_data = $signed(rt_r) >>> rs_r[4:0];
			ex_pkg::OP_MFHI: alu_data = hi;
			ex_pkg::OP_MFLO: alu_data = lo;
			ex_pkg::OP_ADD, ex_pkg::OP_ADDU: alu_data = add_u;
			ex_pkg::OP_SUB, ex_pkg::OP_SUBU: alu_data = sub_u;
			ex_pkg::OP_AND:  alu_data = rs_r & rt_r;
			ex_pkg::OP_OR:   alu_data = rs_r | rt_r;
			ex_pkg::OP_XOR:  alu_data = rs_r ^ rt_r;
			ex_pkg::OP_NOR:  alu_data = ~(rs_r | rt_r);
			ex_pkg::OP_SLT:  alu_data = {{(W-1){1'b0}}, signed_lt};
			ex_pkg::OP_SLTU: alu_data = {{(W-1){1'b0}}, rs_r < rt_r};
			ex_pkg::OP_CLZ:  alu_data = clz_cnt;
			ex_pkg::OP_CLO:  alu_data = clo_cnt;
			// MT*, MULT*, invalid
			default:         alu_data = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state   <= ex_pkg::IDLE;
			q.ack   <= 1'b0;
			out_req <= 1'b0;
			hi      <= '0;
			lo      <= '0;
		end
		else
		begin
			if (q.ack && !q.req)
				q.ack <= 1'b0;
			case (state)
				ex_pkg::IDLE:
				begin
					if (accept)
					begin
						q.ack <= 1'b1;
						state <= is_mul ? ex_pkg::MUL_WAIT : ex_pkg::RESULT;
					end
				end
				ex_pkg::MUL_WAIT:
				begin
					if (!mul_busy)
						state <= ex_pkg::RESULT;
				end
				ex_pkg::RESULT:
				begin
					case (op_r)
						ex_pkg::OP_MTHI: hi <= rs_r;
						ex_pkg::OP_MTLO: lo <= rs_r;
						ex_pkg::OP_MULT, ex_pkg::OP_MULTU: {hi, lo} <= mul_product;
						default: ;
					endcase
					out_req <= 1'b1;
					state   <= ex_pkg::RELEASE;
				end
				default:
				begin
					if (out_req && out_ack)
						out_req <= 1'b0;
					else if (!out_req && !out_ack)
						state <= ex_pkg::IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			op_r    <= q.op;
			rs_r    <= q.rs_val;
			rt_r    <= q.rt_val;
			shamt_r <= q.shamt;
		end
		if (state == ex_pkg::RESULT)
		begin
			out_data     <= overflow ? '0 : alu_data;
			out_overflow <= overflow;
			out_invalid  <= (op_r == ex_pkg::OP_INVALID);
		end
	end

endmodule

`default_nettype wire

// ==== logic/mul_unit.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "ex_params.svh"

module mul_unit (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  start,
	input  logic                  is_signed,
	input  logic [`EX_WORD-1:0]   a,
	input  logic [`EX_WORD-1:0]   b,
	output logic                  busy,
	output logic [2*`EX_WORD-1:0] product
);

	localparam int W  = `EX_WORD;
	localparam int CW = $clog2(`EX_MUL_CYCLES + 1);

	logic [W-1:0]   a_mag;
	logic [W-1:0]   b_mag;
	logic [W-1:0]   mcand;
	logic [2*W-1:0] acc;
	logic [2*W-1:0] acc_next;
	logic [W:0]     sum;
	logic           neg;
	logic [CW-1:0]  cnt;

	assign a_mag = (is_signed && a[W-1]) ? -a : a;
	assign b_mag = (is_signed && b[W-1]) ? -b : b;

	// upper half accumulates, multiplier shifts out of the lower half
	assign sum      = {1'b0, acc[2*W-1:W]} + (acc[0] ? {1'b0, mcand} : '0);
	assign acc_next = {sum, acc[W-1:1]};

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			cnt  <= '0;
		end
		else if (start)
		begin
			busy <= 1'b1;
			cnt  <= CW'(`EX_MUL_CYCLES);
		end
		else if (busy)
		begin
			cnt <= cnt - 1'b1;
			if (cnt == CW'(1))
				busy <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (start)
		begin
			mcand <= a_mag;
			acc   <= {{W{1'b0}}, b_mag};
			neg   <= is_signed && (a[W-1] ^ b[W-1]);
		end
		else if (busy)
		begin
			acc <= acc_next;
			if (cnt == CW'(1))
				product <= neg ? -acc_next : acc_next;
		end
	end

endmodule

`default_nettype wire

// ==== logic/count_lead.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "ex_params.svh"

module count_lead (
	input  logic                bit_val,
	input  logic [`EX_WORD-1:0] val,
	output logic [`EX_WORD-1:0] count
);

	logic stop;

	// scan from msb until the first mismatch
	always_comb
	begin
		count = '0;
		stop  = 1'b0;
		for (int i = `EX_WORD-1; i >= 0; i--)
		begin
			if (!stop && val[i] == bit_val)
				count = count + `EX_WORD'(1);
			else
				stop = 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== logic/issue_queue.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "ex_params.svh"

module issue_queue (
	input  logic      clk,
	input  logic      rst,
	stage_if.receiver up,
	stage_if.sender   down
);

	localparam int AW = $clog2(`EX_QDEPTH);

	ex_pkg::issue_t mem [`EX_QDEPTH];
	ex_pkg::issue_t in_pkt;
	ex_pkg::issue_t head;
	logic [AW-1:0]  wr_ptr;
	logic [AW-1:0]  rd_ptr;
	logic [AW:0]    count;
	logic           full;
	logic           empty;
	logic           push;
	logic           pop;
	logic           pend;

	assign full  = (count == (AW+1)'(`EX_QDEPTH));
	assign empty = (count == '0);

	assign in_pkt = '{up.op, up.rs_val, up.rt_val, up.shamt};
	assign push   = up.req && !up.ack && !full;
	// entry leaves once the consumer drops ack
	assign pop    = pend && !down.ack;

	assign head        = mem[rd_ptr];
	assign down.op     = head.op;
	assign down.rs_val = head.rs_val;
	assign down.rt_val = head.rt_val;
	assign down.shamt  = head.shamt;

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= in_pkt;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			up.ack   <= 1'b0;
			down.req <= 1'b0;
			pend     <= 1'b0;
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
		end
		else
		begin
			if (push)
			begin
				up.ack <= 1'b1;
				wr_ptr <= wr_ptr + 1'b1;
			end
			else if (up.ack && !up.req)
				up.ack <= 1'b0;

			if (!empty && !down.req && !down.ack && !pend)
				down.req <= 1'b1;
			else if (down.req && down.ack)
			begin
				down.req <= 1'b0;
				pend     <= 1'b1;
			end
			else if (pop)
			begin
				pend   <= 1'b0;
				rd_ptr <= rd_ptr + 1'b1;
			end

			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/op_decode.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "ex_params.svh"

module op_decode (
	input  logic                clk,
	input  logic                rst,
	input  logic                in_req,
	output logic                in_ack,
	input  logic [5:0]          in_funct,
	input  logic                in_special2,
	input  logic [`EX_WORD-1:0] in_rs_val,
	input  logic [`EX_WORD-1:0] in_rt_val,
	input  logic [4:0]          in_shamt,
	stage_if.sender             q
);

	ex_pkg::op_t dec_op;
	logic        take;

	// downstream must be fully idle before a new op is taken
	assign take = in_req && !in_ack && !q.req && !q.ack;

	always_comb
	begin
		dec_op = ex_pkg::OP_INVALID;
		if (in_special2)
		begin
			case (in_funct)
				`FN_CLZ: dec_op = ex_pkg::OP_CLZ;
				`FN_CLO: dec_op = ex_pkg::OP_CLO;
				default: dec_op = ex_pkg::OP_INVALID;
			endcase
		end
		else
		begin
			case (in_funct)
				`FN_SLL:   dec_op = ex_pkg::OP_SLL;
				`FN_SRL:   dec_op = ex_pkg::OP_SRL;
				`FN_SRA:   dec_op = ex_pkg::OP_SRA;
				`FN_SLLV:  dec_op = ex_pkg::OP_SLLV;
				`FN_SRLV:  dec_op = ex_pkg::OP_SRLV;
				`FN_SRAV:  dec_op = ex_pkg::OP_SRAV;
				`FN_MFHI:  dec_op = ex_pkg::OP_MFHI;
				`FN_MTHI:  dec_op = ex_pkg::OP_MTHI;
				`FN_MFLO:  dec_op = ex_pkg::OP_MFLO;
				`FN_MTLO:  dec_op = ex_pkg::OP_MTLO;
				`FN_MULT:  dec_op = ex_pkg::OP_MULT;
				`FN_MULTU: dec_op = ex_pkg::OP_MULTU;
				`FN_ADD:   dec_op = ex_pkg::OP_ADD;
				`FN_ADDU:  dec_op = ex_pkg::OP_ADDU;
				`FN_SUB:   dec_op = ex_pkg::OP_SUB;
				`FN_SUBU:  dec_op = ex_pkg::OP_SUBU;
				`FN_AND:   dec_op = ex_pkg::OP_AND;
				`FN_OR:    dec_op = ex_pkg::OP_OR;
				`FN_XOR:   dec_op = ex_pkg::OP_XOR;
				`FN_NOR:   dec_op = ex_pkg::OP_NOR;
				`FN_SLT:   dec_op = ex_pkg::OP_SLT;
				`FN_SLTU:  dec_op = ex_pkg::OP_SLTU;
				default:   dec_op = ex_pkg::OP_INVALID;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			in_ack <= 1'b0;
			q.req  <= 1'b0;
		end
		else
		begin
			if (take)
			begin
				in_ack <= 1'b1;
				q.req  <= 1'b1;
			end
			else if (in_ack && !in_req)
				in_ack <= 1'b0;
			if (q.req && q.ack)
				q.req <= 1'b0;
		end
	end

	// packet held stable while q.req is high
	always_ff @(posedge clk)
	begin
		if (take)
		begin
			q.op     <= dec_op;
			q.rs_val <= in_rs_val;
			q.rt_val <= in_rt_val;
			q.shamt  <= in_shamt;
		end
	end

endmodule

`default_nettype wire

// ==== logic/stage_if.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "ex_params.svh"

interface stage_if;
	logic                req;
	logic                ack;
	ex_pkg::op_t         op;
	logic [`EX_WORD-1:0] rs_val;
	logic [`EX_WORD-1:0] rt_val;
	logic [4:0]          shamt;

	modport sender (output req, op, rs_val, rt_val, shamt, input ack);
	modport receiver (input req, op, rs_val, rt_val, shamt, output ack);
endinterface

`default_nettype wire

// ==== logic/ex_pkg.sv ====
`default_nettype none

`include "ex_params.svh"

package ex_pkg;

	typedef enum logic [4:0] {
		OP_SLL,
		OP_SRL,
		OP_SRA,
		OP_SLLV,
		OP_SRLV,
		OP_SRAV,
		OP_MFHI,
		OP_MTHI,
		OP_MFLO,
		OP_MTLO,
		OP_MULT,
		OP_MULTU,
		OP_ADD,
		OP_ADDU,
		OP_SUB,
		OP_SUBU,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_NOR,
		OP_SLT,
		OP_SLTU,
		OP_CLZ,
		OP_CLO,
		OP_INVALID
	} op_t;

	typedef enum logic [1:0] {
		IDLE,
		MUL_WAIT,
		RESULT,
		RELEASE
	} exec_state_t;

	// one queued operation
	typedef struct packed {
		op_t                 op;
		logic [`EX_WORD-1:0] rs_val;
		logic [`EX_WORD-1:0] rt_val;
		logic [4:0]          shamt;
	} issue_t;

endpackage

`default_nettype wire

// ==== include/ex_params.svh ====
`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

`define EX_WORD       32
`define EX_QDEPTH     4
`define EX_MUL_CYCLES 32

// SPECIAL funct field
`define FN_SLL   6'h00
`define FN_SRL   6'h02
`define FN_SRA   6'h03
`define FN_SLLV  6'h04
`define FN_SRLV  6'h06
`define FN_SRAV  6'h07
`define FN_MFHI  6'h10
`define FN_MTHI  6'h11
`define FN_MFLO  6'h12
`define FN_MTLO  6'h13
`define FN_MULT  6'h18
`define FN_MULTU 6'h19
`define FN_ADD   6'h20
`define FN_ADDU  6'h21
`define FN_SUB   6'h22
`define FN_SUBU  6'h23
`define FN_AND   6'h24
`define FN_OR    6'h25
`define FN_XOR   6'h26
`define FN_NOR   6'h27
`define FN_SLT   6'h2a
`define FN_SLTU  6'h2b

// SPECIAL2 funct field
`define FN_CLZ   6'h20
`define FN_CLO   6'h21

`endif
